// File: rv_decode_pkg.sv
// rv_decode_pkg: opcode, funct, alu and memory encodings, instruction union, control bundle, fetch token
package rv_decode_pkg;

	localparam int REG_ADDR_W = 5;
	localparam int PC_MAX_W   = 32;

	// addi x0, x0, 0
	localparam logic [31:0] NOP_WORD = 32'h0000_0013;

	typedef enum logic [6:0] {
		OPC_LOAD     = 7'b000_0011,
		OPC_STORE    = 7'b010_0011,
		OPC_BRANCH   = 7'b110_0011,
		OPC_JAL      = 7'b110_1111,
		OPC_JALR     = 7'b110_0111,
		OPC_OP_IMM   = 7'b001_0011,
		OPC_OP       = 7'b011_0011,
		OPC_LUI      = 7'b011_0111,
		OPC_AUIPC    = 7'b001_0111,
		OPC_MISC_MEM = 7'b000_1111,
		OPC_SYSTEM   = 7'b111_0011
	} opcode_e;

	// branch compares
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// OP and OP_IMM share these
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// load/store widths
	localparam logic [2:0] F3_LS_B  = 3'b000;
	localparam logic [2:0] F3_LS_H  = 3'b001;
	localparam logic [2:0] F3_LS_W  = 3'b010;
	localparam logic [2:0] F3_LS_BU = 3'b100;
	localparam logic [2:0] F3_LS_HU = 3'b101;

	localparam logic [2:0] F3_CSRRW  = 3'b001;
	localparam logic [2:0] F3_CSRRS  = 3'b010;
	localparam logic [2:0] F3_CSRRC  = 3'b011;
	localparam logic [2:0] F3_CSRRWI = 3'b101;
	localparam logic [2:0] F3_CSRRSI = 3'b110;
	localparam logic [2:0] F3_CSRRCI = 3'b111;

	localparam logic [6:0] F7_BASE   = 7'b000_0000;
	localparam logic [6:0] F7_ALT    = 7'b010_0000;
	localparam logic [6:0] F7_MULDIV = 7'b000_0001;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
		ALU_SRA, ALU_OR, ALU_AND, ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU
	} alu_op_e;

	typedef enum logic [2:0] {BYTE_S, BYTE_U, HALF_S, HALF_U, WORD} mem_size_e;

	typedef enum logic [2:0] {IMM_U, IMM_J, IMM_I, IMM_B, IMM_S, IMM_Z} imm_sel_e;

	// writeback source
	localparam logic [1:0] RD_SEL_ALU = 2'b00;
	localparam logic [1:0] RD_SEL_PC4 = 2'b01;
	localparam logic [1:0] RD_SEL_IMM = 2'b10;

	// csr_sel bits: 0 reg set/clear, 1 any set/clear, 2 csr op, 3 clear form
	localparam int CSR_SEL_CLEAR = 3;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	typedef struct packed {
		logic       rf_we;
		logic [1:0] rd_sel;
		logic       load_wb;
		logic       alu_op2_imm;
		alu_op_e    alu_op;
		logic       mul_div;
		logic       mem_we;
		logic       mem_re;
		mem_size_e  mem_size;
		logic       branch;
		logic       jump;
		logic       jalr;
		logic       csr_we;
		logic       csr_re;
		logic [3:0] csr_sel;
	} ctrl_t;

	typedef struct packed {
		logic                valid;
		logic [PC_MAX_W-1:0] pc;
	} fetch_tok_t;

endpackage

// File: id_pipe_reg.sv
// id_pipe_reg: fetch token register and one-entry instruction buffer for stalls
module id_pipe_reg #(
	parameter int PC_W = 32
) (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      stall,
	input  rv_decode_pkg::fetch_tok_t if_tok,
	input  logic                      imem_valid,
	input  logic [31:0]               imem_rdata,
	output rv_decode_pkg::fetch_tok_t tok,
	output rv_decode_pkg::inst_u      inst,
	output logic                      resp_ok
);

	logic            tok_valid_q;
	logic [PC_W-1:0] pc_q;
	logic            buf_hold;
	logic            buf_valid;
	logic [31:0]     buf_word;
	logic            buf_load;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			tok_valid_q <= 1'b0;
		end else if (!stall) begin
			tok_valid_q <= if_tok.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pc_q <= if_tok.pc[PC_W-1:0];
		end
	end

	// sets on the first stalled cycle with a real response and drops once stall is gone
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			buf_hold <= 1'b0;
		end else if (stall && tok_valid_q && imem_valid && !buf_hold) begin
			buf_hold <= 1'b1;
		end else if (!stall && buf_hold) begin
			buf_hold <= 1'b0;
		end
	end

	// buffer tracks memory every cycle until it is holding in a stall
	assign buf_load = !(buf_hold && stall);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			buf_valid <= 1'b0;
		end else if (buf_load) begin
			buf_valid <= imem_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (buf_load) begin
			buf_word <= imem_rdata;
		end
	end

	always_comb begin
		tok            = '0;
		tok.valid      = tok_valid_q;
		tok.pc[PC_W-1:0] = pc_q;
	end

	assign inst    = buf_hold ? buf_word : imem_rdata;
	assign resp_ok = buf_hold ? buf_valid : imem_valid;

endmodule

// File: inst_decoder.sv
// inst_decoder: opcode classes, RV32IM instruction decode, alu/memory/csr control fields
module inst_decoder (
	input  rv_decode_pkg::inst_u    inst,
	input  logic                    valid,
	output rv_decode_pkg::ctrl_t    ctrl_raw,
	output rv_decode_pkg::imm_sel_e imm_sel,
	output logic                    is_fence,
	output logic                    uses_rs2
);

	logic is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load;
	logic is_store, is_op_imm, is_op, is_misc, is_system;
	logic [2:0] f3;
	logic [6:0] f7;
	logic f7_base, f7_alt, f7_ok, mul_div;
	logic is_csrrw, is_csrrs, is_csrrc, is_csrrwi, is_csrrsi, is_csrrci;
	logic csr_set_clr_reg, csr_set_clr_imm, is_csr;
	logic rs1_nz, rd_nz;
	rv_decode_pkg::alu_op_e   alu_op;
	rv_decode_pkg::mem_size_e mem_size;

	assign f3 = inst.r_fmt.funct3;
	assign f7 = inst.r_fmt.funct7;

	// no opcode class is raised without a valid token
	always_comb begin
		{is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load} = '0;
		{is_store, is_op_imm, is_op, is_misc, is_system} = '0;
		if (valid) begin
			case (inst.r_fmt.opcode)
				rv_decode_pkg::OPC_LUI:      is_lui    = 1'b1;
				rv_decode_pkg::OPC_AUIPC:    is_auipc  = 1'b1;
				rv_decode_pkg::OPC_JAL:      is_jal    = 1'b1;
				rv_decode_pkg::OPC_JALR:     is_jalr   = 1'b1;
				rv_decode_pkg::OPC_BRANCH:   is_branch = 1'b1;
				rv_decode_pkg::OPC_LOAD:     is_load   = 1'b1;
				rv_decode_pkg::OPC_STORE:    is_store  = 1'b1;
				rv_decode_pkg::OPC_OP_IMM:   is_op_imm = 1'b1;
				rv_decode_pkg::OPC_OP:       is_op     = 1'b1;
				rv_decode_pkg::OPC_MISC_MEM: is_misc   = 1'b1;
				rv_decode_pkg::OPC_SYSTEM:   is_system = 1'b1;
				default: ;
			endcase
		end
	end

	assign f7_base = (f7 == rv_decode_pkg::F7_BASE);
	assign f7_alt  = (f7 == rv_decode_pkg::F7_ALT);
	// immediate forms carry no funct7 except for shifts
	assign f7_ok   = is_op_imm || f7_base;
	assign mul_div = is_op && (f7 == rv_decode_pkg::F7_MULDIV);

	assign is_csrrw  = is_system && (f3 == rv_decode_pkg::F3_CSRRW);
	assign is_csrrs  = is_system && (f3 == rv_decode_pkg::F3_CSRRS);
	assign is_csrrc  = is_system && (f3 == rv_decode_pkg::F3_CSRRC);
	assign is_csrrwi = is_system && (f3 == rv_decode_pkg::F3_CSRRWI);
	assign is_csrrsi = is_system && (f3 == rv_decode_pkg::F3_CSRRSI);
	assign is_csrrci = is_system && (f3 == rv_decode_pkg::F3_CSRRCI);
	assign csr_set_clr_reg = is_csrrs || is_csrrc;
	assign csr_set_clr_imm = is_csrrsi || is_csrrci;
	assign is_csr = is_csrrw || is_csrrwi || csr_set_clr_reg || csr_set_clr_imm;

	// rs1 field doubles as uimm for the immediate forms
	assign rs1_nz = (inst.i_fmt.rs1 != '0);
	assign rd_nz  = (inst.i_fmt.rd != '0);

	always_comb begin
		alu_op = rv_decode_pkg::ALU_ADD;
		if (is_branch) begin
			case (f3)
				rv_decode_pkg::F3_BEQ:  alu_op = rv_decode_pkg::ALU_SEQ;
				rv_decode_pkg::F3_BNE:  alu_op = rv_decode_pkg::ALU_SNE;
				rv_decode_pkg::F3_BLT:  alu_op = rv_decode_pkg::ALU_SLT;
				rv_decode_pkg::F3_BGE:  alu_op = rv_decode_pkg::ALU_SGE;
				rv_decode_pkg::F3_BLTU: alu_op = rv_decode_pkg::ALU_SLTU;
				rv_decode_pkg::F3_BGEU: alu_op = rv_decode_pkg::ALU_SGEU;
				default: ;
			endcase
		end else if (is_op_imm || (is_op && !mul_div)) begin
			case (f3)
				rv_decode_pkg::F3_ADD_SUB: begin
					if (is_op && f7_alt) alu_op = rv_decode_pkg::ALU_SUB;
				end
				rv_decode_pkg::F3_SLL: if (f7_base) alu_op = rv_decode_pkg::ALU_SLL;
				rv_decode_pkg::F3_SLT: if (f7_ok) alu_op = rv_decode_pkg::ALU_SLT;
				rv_decode_pkg::F3_SLTU: if (f7_ok) alu_op = rv_decode_pkg::ALU_SLTU;
				rv_decode_pkg::F3_XOR: if (f7_ok) alu_op = rv_decode_pkg::ALU_XOR;
				rv_decode_pkg::F3_SRL_SRA: begin
					if (f7_base) alu_op = rv_decode_pkg::ALU_SRL;
					else if (f7_alt) alu_op = rv_decode_pkg::ALU_SRA;
				end
				rv_decode_pkg::F3_OR: if (f7_ok) alu_op = rv_decode_pkg::ALU_OR;
				rv_decode_pkg::F3_AND: if (f7_ok) alu_op = rv_decode_pkg::ALU_AND;
				default: ;
			endcase
		end else if (is_csrrs || is_csrrsi) begin
			alu_op = rv_decode_pkg::ALU_OR;
		end else if (is_csrrc || is_csrrci) begin
			alu_op = rv_decode_pkg::ALU_AND;
		end
	end

	always_comb begin
		mem_size = rv_decode_pkg::BYTE_S;
		if (is_load || is_store) begin
			case (f3)
				rv_decode_pkg::F3_LS_B:  mem_size = rv_decode_pkg::BYTE_S;
				rv_decode_pkg::F3_LS_H:  mem_size = rv_decode_pkg::HALF_S;
				rv_decode_pkg::F3_LS_W:  mem_size = rv_decode_pkg::WORD;
				rv_decode_pkg::F3_LS_BU: mem_size = rv_decode_pkg::BYTE_U;
				rv_decode_pkg::F3_LS_HU: mem_size = rv_decode_pkg::HALF_U;
				default: ;
			endcase
		end
	end

	always_comb begin
		if (is_jal) imm_sel = rv_decode_pkg::IMM_J;
		else if (is_jalr || is_load || is_op_imm) imm_sel = rv_decode_pkg::IMM_I;
		else if (is_branch) imm_sel = rv_decode_pkg::IMM_B;
		else if (is_store) imm_sel = rv_decode_pkg::IMM_S;
		else if (is_csr) imm_sel = rv_decode_pkg::IMM_Z;
		else imm_sel = rv_decode_pkg::IMM_U;
	end

	always_comb begin
		ctrl_raw = '0;
		ctrl_raw.rf_we = is_lui || is_auipc || is_jal || is_jalr || is_load ||
			is_op_imm || is_op || is_system;
		if (is_lui) ctrl_raw.rd_sel = rv_decode_pkg::RD_SEL_IMM;
		else if (is_jal || is_jalr) ctrl_raw.rd_sel = rv_decode_pkg::RD_SEL_PC4;
		else ctrl_raw.rd_sel = rv_decode_pkg::RD_SEL_ALU;
		ctrl_raw.load_wb     = is_load;
		// auipc adds pc and the U immediate in the alu
		ctrl_raw.alu_op2_imm = is_auipc || is_jalr || is_load || is_store || is_op_imm || is_csr;
		ctrl_raw.alu_op      = alu_op;
		ctrl_raw.mul_div     = mul_div;
		ctrl_raw.mem_we      = is_store;
		ctrl_raw.mem_re      = is_load;
		ctrl_raw.mem_size    = mem_size;
		ctrl_raw.branch      = is_branch;
		ctrl_raw.jump        = is_jal || is_jalr;
		ctrl_raw.jalr        = is_jalr;
		// set/clear with a zero source leave the csr untouched
		ctrl_raw.csr_we = is_csrrw || is_csrrwi || ((csr_set_clr_reg || csr_set_clr_imm) && rs1_nz);
		ctrl_raw.csr_re = ((is_csrrw || is_csrrwi) && rd_nz) || csr_set_clr_reg || csr_set_clr_imm;
		ctrl_raw.csr_sel[0] = csr_set_clr_reg;
		ctrl_raw.csr_sel[1] = csr_set_clr_reg || csr_set_clr_imm;
		ctrl_raw.csr_sel[2] = is_csr;
		ctrl_raw.csr_sel[rv_decode_pkg::CSR_SEL_CLEAR] = is_csrrc || is_csrrci;
	end

	// fence and fence.i both leave as a nop
	assign is_fence = is_misc;
	assign uses_rs2 = is_branch || is_op;

endmodule

// File: imm_gen.sv
// imm_gen: U/J/I/B/S immediate build with sign extension, zero-extended csr uimm
module imm_gen (
	input  rv_decode_pkg::inst_u    inst,
	input  rv_decode_pkg::imm_sel_e imm_sel,
	input  logic                    csr_clear,
	output logic [31:0]             imm
);

	logic [31:0] imm_u, imm_j, imm_i, imm_b, imm_s, imm_z;

	assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};

	assign imm_j = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
		inst.j_fmt.imm_10_1, 1'b0};

	assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};

	assign imm_b = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
		inst.b_fmt.imm_4_1, 1'b0};

	assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};

	// clear forms go to the alu as an AND mask
	always_comb begin
		imm_z = {27'b0, inst.i_fmt.rs1};
		if (csr_clear) begin
			imm_z = ~imm_z;
		end
	end

	always_comb begin
		case (imm_sel)
			rv_decode_pkg::IMM_J: imm = imm_j;
			rv_decode_pkg::IMM_I: imm = imm_i;
			rv_decode_pkg::IMM_B: imm = imm_b;
			rv_decode_pkg::IMM_S: imm = imm_s;
			rv_decode_pkg::IMM_Z: imm = imm_z;
			default: imm = imm_u;
		endcase
	end

endmodule

// File: hazard_unit.sv
// hazard_unit: load-use check against execute and missing fetch response
module hazard_unit (
	input  logic                                valid,
	input  logic                                resp_ok,
	input  logic                                ex_mem_re,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] ex_rd,
	input  logic                                uses_rs2,
	output logic                                hazard
);

	logic load_use;
	logic resp_missing;

	// rs2 only counts when the instruction actually reads it
	assign load_use = valid && ex_mem_re &&
		((ex_rd == rs1) || (uses_rs2 && (ex_rd == rs2)));

	assign resp_missing = valid && !resp_ok;

	assign hazard = load_use || resp_missing;

endmodule

// File: decode_stage.sv
// decode_stage: top of the decode stage, sub-module wiring, flush and fence handling
module decode_stage #(
	parameter int PC_W = 32
) (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  rv_decode_pkg::fetch_tok_t            if_tok,
	input  logic                                 imem_valid,
	input  logic [31:0]                          imem_rdata,
	input  logic                                 stall,
	input  logic                                 flush,
	input  logic                                 ex_mem_re,
	// destination of the instruction now in execute
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] ex_load_rd,
	output logic                                 ex_valid,
	output logic [PC_W-1:0]                      ex_pc,
	output rv_decode_pkg::inst_u                 ex_inst,
	output rv_decode_pkg::ctrl_t                 ex_ctrl,
	output logic [31:0]                          ex_imm,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] ex_rd,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2,
	output logic [11:0]                          csr_addr,
	output logic                                 hazard
);

	rv_decode_pkg::fetch_tok_t tok;
	rv_decode_pkg::inst_u      inst;
	logic                      resp_ok;
	rv_decode_pkg::ctrl_t      ctrl_raw;
	rv_decode_pkg::imm_sel_e   imm_sel;
	logic                      is_fence;
	logic                      uses_rs2;

	id_pipe_reg #(
		.PC_W(PC_W)
	) u_pipe_reg (
		.clk        (clk),
		.rstn       (rstn),
		.stall      (stall),
		.if_tok     (if_tok),
		.imem_valid (imem_valid),
		.imem_rdata (imem_rdata),
		.tok        (tok),
		.inst       (inst),
		.resp_ok    (resp_ok)
	);

	inst_decoder u_decoder (
		.inst     (inst),
		.valid    (tok.valid),
		.ctrl_raw (ctrl_raw),
		.imm_sel  (imm_sel),
		.is_fence (is_fence),
		.uses_rs2 (uses_rs2)
	);

	imm_gen u_imm_gen (
		.inst      (inst),
		.imm_sel   (imm_sel),
		.csr_clear (ctrl_raw.csr_sel[rv_decode_pkg::CSR_SEL_CLEAR]),
		.imm       (ex_imm)
	);

	hazard_unit u_hazard (
		.valid     (tok.valid),
		.resp_ok   (resp_ok),
		.ex_mem_re (ex_mem_re),
		.rs1       (rs1),
		.rs2       (rs2),
		.ex_rd     (ex_load_rd),
		.uses_rs2  (uses_rs2),
		.hazard    (hazard)
	);

	assign rs1      = inst.r_fmt.rs1;
	assign rs2      = inst.r_fmt.rs2;
	assign ex_rd    = inst.r_fmt.rd;
	assign csr_addr = inst.i_fmt.imm;
	assign ex_pc    = tok.pc[PC_W-1:0];

	assign ex_valid = !flush && tok.valid && resp_ok;

	always_comb begin
		ex_inst = inst;
		if (is_fence || flush) begin
			ex_inst = rv_decode_pkg::NOP_WORD;
		end
	end

	// flushed slot keeps its selectors but loses every side effect
	always_comb begin
		ex_ctrl = ctrl_raw;
		if (flush) begin
			ex_ctrl.rf_we  = 1'b0;
			ex_ctrl.mem_we = 1'b0;
			ex_ctrl.mem_re = 1'b0;
			ex_ctrl.branch = 1'b0;
			ex_ctrl.jump   = 1'b0;
			ex_ctrl.csr_we = 1'b0;
			ex_ctrl.csr_re = 1'b0;
		end
	end

endmodule

// File: tb_decode_vectors.svh
// decode table of instruction words with expected control bundle and immediate
// columns: word, flags {rf_we load_wb op2_imm mul_div mem_we mem_re branch jump jalr},
//          rd_sel, alu_op, mem_size (0 BS 1 BU 2 HS 3 HU 4 W), imm, imm checked
task automatic load_vectors();
	row(32'h123452B7, 9'b100000000, 2'd2, rv_decode_pkg::ALU_ADD, 3'd0, 32'h12345000, 1'b1);
	row(32'hFFFFF317, 9'b101000000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd0, 32'hFFFFF000, 1'b1);
	row(32'hFFDFF0EF, 9'b100000010, 2'd1, rv_decode_pkg::ALU_ADD, 3'd0, 32'hFFFFFFFC, 1'b1);
	row(32'h008100E7, 9'b101000011, 2'd1, rv_decode_pkg::ALU_ADD, 3'd0, 32'h00000008, 1'b1);
	// six branches, offset +8
	row(32'h00208463, 9'b000000100, 2'd0, rv_decode_pkg::ALU_SEQ, 3'd0, 32'h00000008, 1'b1);
	row(32'h00209463, 9'b000000100, 2'd0, rv_decode_pkg::ALU_SNE, 3'd0, 32'h00000008, 1'b1);
	row(32'h0020C463, 9'b000000100, 2'd0, rv_decode_pkg::ALU_SLT, 3'd0, 32'h00000008, 1'b1);
	row(32'h0020D463, 9'b000000100, 2'd0, rv_decode_pkg::ALU_SGE, 3'd0, 32'h00000008, 1'b1);
	row(32'h0020E463, 9'b000000100, 2'd0, rv_decode_pkg::ALU_SLTU, 3'd0, 32'h00000008, 1'b1);
	row(32'h0020F463, 9'b000000100, 2'd0, rv_decode_pkg::ALU_SGEU, 3'd0, 32'h00000008, 1'b1);
	// loads at -4(x1)
	row(32'hFFC08183, 9'b111001000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd0, 32'hFFFFFFFC, 1'b1);
	row(32'hFFC09183, 9'b111001000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd2, 32'hFFFFFFFC, 1'b1);
	row(32'hFFC0A183, 9'b111001000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd4, 32'hFFFFFFFC, 1'b1);
	row(32'hFFC0C183, 9'b111001000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd1, 32'hFFFFFFFC, 1'b1);
	row(32'hFFC0D183, 9'b111001000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd3, 32'hFFFFFFFC, 1'b1);
	// stores
	row(32'h00208623, 9'b001010000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd0, 32'h0000000C, 1'b1);
	row(32'h00209623, 9'b001010000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd2, 32'h0000000C, 1'b1);
	row(32'h0020A623, 9'b001010000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd4, 32'h0000000C, 1'b1);
	row(32'hFE20AFA3, 9'b001010000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd4, 32'hFFFFFFFF, 1'b1);
	// OP_IMM with imm -1, then shifts by 3
	row(32'hFFF08293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd0, 32'hFFFFFFFF, 1'b1);
	row(32'hFFF0A293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_SLT, 3'd0, 32'hFFFFFFFF, 1'b1);
	row(32'hFFF0B293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_SLTU, 3'd0, 32'hFFFFFFFF, 1'b1);
	row(32'hFFF0C293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_XOR, 3'd0, 32'hFFFFFFFF, 1'b1);
	row(32'hFFF0E293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_OR, 3'd0, 32'hFFFFFFFF, 1'b1);
	row(32'hFFF0F293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_AND, 3'd0, 32'hFFFFFFFF, 1'b1);
	row(32'h00309293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_SLL, 3'd0, 32'h00000003, 1'b1);
	row(32'h0030D293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_SRL, 3'd0, 32'h00000003, 1'b1);
	row(32'h4030D293, 9'b101000000, 2'd0, rv_decode_pkg::ALU_SRA, 3'd0, 32'h00000403, 1'b1);
	// OP, mul/div and fence carry no immediate
	row(32'h002082B3, 9'b100000000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd0, 32'h0, 1'b0);
	row(32'h402082B3, 9'b100000000, 2'd0, rv_decode_pkg::ALU_SUB, 3'd0, 32'h0, 1'b0);
	row(32'h002092B3, 9'b100000000, 2'd0, rv_decode_pkg::ALU_SLL, 3'd0, 32'h0, 1'b0);
	row(32'h0020D2B3, 9'b100000000, 2'd0, rv_decode_pkg::ALU_SRL, 3'd0, 32'h0, 1'b0);
	row(32'h4020D2B3, 9'b100000000, 2'd0, rv_decode_pkg::ALU_SRA, 3'd0, 32'h0, 1'b0);
	row(32'h0020F2B3, 9'b100000000, 2'd0, rv_decode_pkg::ALU_AND, 3'd0, 32'h0, 1'b0);
	row(32'h022082B3, 9'b100100000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd0, 32'h0, 1'b0);
	row(32'h0220C2B3, 9'b100100000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd0, 32'h0, 1'b0);
	row(32'h0FF0000F, 9'b000000000, 2'd0, rv_decode_pkg::ALU_ADD, 3'd0, 32'h0, 1'b0);
endtask

// File: tb_decode_stage.sv
// tb_decode_stage: clock, reset, DUT, LFSR, compare tasks, decode/csr/flush/hazard/stall checks
module tb_decode_stage;
	timeunit 1ns;
	timeprecision 1ns;

	typedef struct packed {
		logic [31:0]          word;
		rv_decode_pkg::ctrl_t ctrl;
		logic [31:0]          imm;
		logic                 imm_chk;
	} vec_t;

	logic                      clk;
	logic                      rstn;
	rv_decode_pkg::fetch_tok_t if_tok;
	logic                      imem_valid;
	logic [31:0]               imem_rdata;
	logic                      stall;
	logic                      flush;
	logic                      ex_mem_re;
	logic [4:0]                ex_load_rd;
	logic                      ex_valid;
	logic [31:0]               ex_pc;
	rv_decode_pkg::inst_u      ex_inst;
	rv_decode_pkg::ctrl_t      ex_ctrl;
	logic [31:0]               ex_imm;
	logic [4:0]                ex_rd;
	logic [4:0]                rs1;
	logic [4:0]                rs2;
	logic [11:0]               csr_addr;
	logic                      hazard;

	vec_t        vectors[$];
	logic [15:0] lfsr = 16'd60;

	decode_stage #(
		.PC_W(32)
	) UUT (
		.clk(clk), .rstn(rstn), .if_tok(if_tok), .imem_valid(imem_valid),
		.imem_rdata(imem_rdata), .stall(stall), .flush(flush), .ex_mem_re(ex_mem_re),
		.ex_load_rd(ex_load_rd), .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(ex_inst),
		.ex_ctrl(ex_ctrl), .ex_imm(ex_imm), .ex_rd(ex_rd), .rs1(rs1), .rs2(rs2),
		.csr_addr(csr_addr), .hazard(hazard)
	);

	`include "tb_decode_vectors.svh"

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	// guard against a stuck run
	initial begin
		#5_000_000;
		$display("ERROR: simulation ran past its time limit");
		abort_run();
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [4:0] rand_bits(input int n);
		logic [4:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			val = {val[3:0], lfsr[0]};
		end
		return val;
	endfunction

	task automatic row(input logic [31:0] word, input logic [8:0] f, input logic [1:0] rd_sel,
		input rv_decode_pkg::alu_op_e alu, input logic [2:0] size, input logic [31:0] imm,
		input logic chk);
		vec_t v;
		v = '0;
		v.word = word;
		{v.ctrl.rf_we, v.ctrl.load_wb, v.ctrl.alu_op2_imm, v.ctrl.mul_div} = f[8:5];
		{v.ctrl.mem_we, v.ctrl.mem_re, v.ctrl.branch, v.ctrl.jump, v.ctrl.jalr} = f[4:0];
		v.ctrl.rd_sel = rd_sel;
		v.ctrl.alu_op = alu;
		v.ctrl.mem_size = rv_decode_pkg::mem_size_e'(size);
		v.imm = imm;
		v.imm_chk = chk;
		vectors.push_back(v);
	endtask

	task automatic check_ctrl(input string name, input rv_decode_pkg::ctrl_t got,
		input rv_decode_pkg::ctrl_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_reg(input string name,
		input logic [rv_decode_pkg::REG_ADDR_W-1:0] got,
		input logic [rv_decode_pkg::REG_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// token in one cycle and its memory word in the next
	task automatic apply_word(input logic [31:0] word, input logic [31:0] pc,
		input logic flush_en, input logic mem_re, input logic [4:0] load_rd);
		@(posedge clk);
		#5;
		if_tok.valid = 1'b1;
		if_tok.pc = pc;
		imem_valid = 1'b0;
		flush = 1'b0;
		ex_mem_re = 1'b0;
		@(posedge clk);
		#5;
		if_tok = '0;
		imem_valid = 1'b1;
		imem_rdata = word;
		flush = flush_en;
		ex_mem_re = mem_re;
		ex_load_rd = load_rd;
		#35;
	endtask

	task automatic wait_valid(input int timeout);
		int n;
		n = 0;
		while (!ex_valid && n < timeout) begin
			#1;
			n++;
		end
		if (!ex_valid) begin
			$display("ERROR: ex_valid did not rise within %0d ns", timeout);
			abort_run();
		end
	endtask

	task automatic check_row(input vec_t v, input logic [31:0] pc, input logic flushed);
		rv_decode_pkg::ctrl_t exp_ctrl;
		logic [31:0]          exp_inst;
		exp_ctrl = v.ctrl;
		if (flushed) begin
			{exp_ctrl.rf_we, exp_ctrl.mem_we, exp_ctrl.mem_re, exp_ctrl.branch} = '0;
			{exp_ctrl.jump, exp_ctrl.csr_we, exp_ctrl.csr_re} = '0;
		end
		exp_inst = (flushed || v.word[6:0] == 7'h0F) ? rv_decode_pkg::NOP_WORD : v.word;
		check_bit("ex_valid", ex_valid, !flushed);
		check_ctrl("ex_ctrl", ex_ctrl, exp_ctrl);
		if (v.imm_chk) begin
			check_word("ex_imm", ex_imm, v.imm);
		end
		check_word("ex_inst", ex_inst, exp_inst);
		check_word("ex_pc", ex_pc, pc);
		check_reg("rs1", rs1, v.word[19:15]);
		check_reg("rs2", rs2, v.word[24:20]);
		check_reg("ex_rd", ex_rd, v.word[11:7]);
		check_bit("hazard", hazard, 1'b0);
	endtask

	initial begin
		logic [2:0]  csr_f3 [6];
		vec_t        v;
		logic [4:0]  src;
		logic [4:0]  dst;
		logic [4:0]  r1;
		logic [4:0]  r2;
		logic [4:0]  erd;
		logic [1:0]  kind;
		logic        set_f;
		logic        clr_f;
		logic [31:0] pc;
		csr_f3 = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
		clk = 1'b0;
		rstn = 1'b0;
		if_tok = '0;
		imem_valid = 1'b0;
		imem_rdata = '0;
		stall = 1'b0;
		flush = 1'b0;
		ex_mem_re = 1'b0;
		ex_load_rd = '0;
		load_vectors();
		repeat (5) @(posedge clk);
		#5;
		rstn = 1'b1;
		check_bit("ex_valid", ex_valid, 1'b0);
		check_bit("hazard", hazard, 1'b0);

		// decode table, then the same rows flushed
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < vectors.size(); i++) begin
				pc = 32'h0000_1000 + 32'(i * 4);
				apply_word(vectors[i].word, pc, pass[0], 1'b0, 5'd0);
				if (pass == 0) begin
					wait_valid(20);
				end
				check_row(vectors[i], pc, pass[0]);
			end
		end

		// csr forms with zero and nonzero source and destination
		for (int f = 0; f < 6; f++) begin
			for (int k = 0; k < 4; k++) begin
				src = k[0] ? (rand_bits(5) | 5'd1) : 5'd0;
				dst = k[1] ? (rand_bits(5) | 5'd1) : 5'd0;
				set_f = (csr_f3[f][1:0] == 2'b10);
				clr_f = (csr_f3[f][1:0] == 2'b11);
				v = '0;
				v.word = {12'h305, src, csr_f3[f], dst, 7'h73};
				v.ctrl.rf_we = 1'b1;
				v.ctrl.alu_op2_imm = 1'b1;
				v.ctrl.alu_op = set_f ? rv_decode_pkg::ALU_OR :
					(clr_f ? rv_decode_pkg::ALU_AND : rv_decode_pkg::ALU_ADD);
				v.ctrl.csr_we = !(set_f || clr_f) || (src != 5'd0);
				v.ctrl.csr_re = set_f || clr_f || (dst != 5'd0);
				v.ctrl.csr_sel = {clr_f, 1'b1, set_f || clr_f, (set_f || clr_f) && !csr_f3[f][2]};
				v.imm = clr_f ? ~{27'b0, src} : {27'b0, src};
				v.imm_chk = 1'b1;
				apply_word(v.word, 32'h0000_2000, 1'b0, 1'b0, 5'd0);
				wait_valid(20);
				check_row(v, 32'h0000_2000, 1'b0);
				check_word("csr_addr", {20'b0, csr_addr}, 32'h0000_0305);
				// same word flushed loses both csr enables
				apply_word(v.word, 32'h0000_2004, 1'b1, 1'b0, 5'd0);
				check_row(v, 32'h0000_2004, 1'b1);
			end
		end

		// load-use against a load in execute
		for (int i = 0; i < 24; i++) begin
			kind = 2'(rand_bits(2));
			r1 = rand_bits(5);
			r2 = rand_bits(5);
			erd = rand_bits(5);
			case (2'(rand_bits(2)))
				2'd0: erd = r1;
				2'd1: erd = r2;
				default: ;
			endcase
			case (kind)
				2'd0: v.word = {7'b0, r2, r1, 3'b0, 5'd5, 7'h33};
				2'd1: v.word = {7'b0, r2, r1, 3'b0, 5'd0, 7'h63};
				default: v.word = {7'b0, r2, r1, 3'b0, 5'd5, 7'h13};
			endcase
			apply_word(v.word, 32'h0000_3000, 1'b0, 1'b1, erd);
			wait_valid(20);
			check_bit("hazard", hazard, (erd == r1) || (kind < 2'd2 && erd == r2));
		end

		// stall while memory data turns to garbage
		@(posedge clk);
		#5;
		ex_mem_re = 1'b0;
		if_tok.valid = 1'b1;
		if_tok.pc = 32'h0000_0200;
		imem_valid = 1'b0;
		@(posedge clk);
		#5;
		if_tok.pc = 32'h0000_0204;
		imem_valid = 1'b1;
		imem_rdata = vectors[12].word;
		stall = 1'b1;
		#35;
		check_row(vectors[12], 32'h0000_0200, 1'b0);
		for (int c = 0; c < 4; c++) begin
			@(posedge clk);
			#5;
			imem_rdata = 32'hDEAD_BEEF ^ 32'(rand_bits(5));
			imem_valid = 1'(rand_bits(1));
			stall = (c < 3);
			#35;
			check_row(vectors[12], 32'h0000_0200, 1'b0);
		end
		@(posedge clk);
		#5;
		if_tok = '0;
		imem_valid = 1'b1;
		imem_rdata = rv_decode_pkg::NOP_WORD;
		#35;
		check_bit("ex_valid", ex_valid, 1'b1);
		check_word("ex_pc", ex_pc, 32'h0000_0204);

		// token without a memory response
		@(posedge clk);
		#5;
		if_tok.valid = 1'b1;
		if_tok.pc = 32'h0000_0300;
		imem_valid = 1'b0;
		@(posedge clk);
		#5;
		if_tok = '0;
		imem_valid = 1'b0;
		#35;
		check_bit("hazard", hazard, 1'b1);
		check_bit("ex_valid", ex_valid, 1'b0);

		$display("All tests passed");
		$finish;
	end

endmodule

// File: decode_stage.f
+incdir+.
rv_decode_pkg.sv
id_pipe_reg.sv
inst_decoder.sv
imm_gen.sv
hazard_unit.sv
decode_stage.sv
tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns \
	-f decode_stage.f \
	--top-module tb_decode_stage \
	--Mdir obj_dir -o sim_decode

# a fatal check exits nonzero, the log decides the result
./obj_dir/sim_decode > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
	exit 0
else
	exit 1
fi
